//--- tti_pkg.sv
// Shared sizes, CSR addresses and types for the I3C target transaction interface
// Imported by every TTI module and by the testbench
`default_nettype none

package tti_pkg;

  // Queue geometry
  localparam int unsigned TtiDataWidth = 32;
  localparam int unsigned TtiDepth = 8;
  localparam int unsigned TtiCntWidth = 4;
  localparam int unsigned TtiPtrWidth = $clog2(TtiDepth);

  // CSR space
  localparam int unsigned TtiAddrWidth = 3;
  localparam int unsigned ThldFieldWidth = 8;

  localparam logic [TtiAddrWidth-1:0] AddrRxDescPort = 3'd0;
  localparam logic [TtiAddrWidth-1:0] AddrRxDataPort = 3'd1;
  localparam logic [TtiAddrWidth-1:0] AddrTxDescPort = 3'd2;
  localparam logic [TtiAddrWidth-1:0] AddrTxDataPort = 3'd3;
  localparam logic [TtiAddrWidth-1:0] AddrThldCtrl = 3'd4;

  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [TtiAddrWidth-1:0] addr;
    logic [TtiDataWidth-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic                    ack;
    logic [TtiDataWidth-1:0] rdata;
  } csr_rsp_t;

  typedef struct packed {
    logic                   full;
    logic                   empty;
    logic                   thld_flag;
    logic [TtiCntWidth-1:0] count;
  } queue_status_t;

  // Threshold control word, written raw and read back per field
  typedef union packed {
    logic [TtiDataWidth-1:0] raw;
    struct packed {
      logic [ThldFieldWidth-1:0] rx_desc_thld;
      logic [ThldFieldWidth-1:0] tx_desc_thld;
      logic [ThldFieldWidth-1:0] rx_data_thld;
      logic [ThldFieldWidth-1:0] tx_data_thld;
    } fld;
  } thld_ctrl_u;

  typedef enum logic [1:0] {
    QSelRxDesc = 2'd0,
    QSelRxData = 2'd1,
    QSelTxDesc = 2'd2,
    QSelTxData = 2'd3
  } q_sel_e;

endpackage : tti_pkg

`default_nettype wire

//--- tti_csr_decode.sv
// CSR access decode for the TTI queues
// Turns one register request into queue strobes and owns the threshold register
`timescale 1ns/1ps
`default_nettype none

module tti_csr_decode (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  tti_pkg::csr_req_t    csr_req_i,
  input  logic                 rx_desc_empty_i,
  input  logic                 rx_data_empty_i,
  input  logic                 tx_desc_full_i,
  input  logic                 tx_data_full_i,
  output logic                 pop_rx_desc_o,
  output logic                 pop_rx_data_o,
  output logic                 push_tx_desc_o,
  output logic                 push_tx_data_o,
  output tti_pkg::q_sel_e      rd_sel_o,
  output logic                 rd_thld_o,
  output logic                 rd_valid_o,
  output tti_pkg::thld_ctrl_u  thld_ctrl_o
);
  import tti_pkg::*;

  logic       rd_req;
  logic       wr_req;
  thld_ctrl_u thld_q;

  assign rd_req = csr_req_i.req && !csr_req_i.we;
  assign wr_req = csr_req_i.req && csr_req_i.we;

  // Port reads pop only when there is something to return
  assign pop_rx_desc_o = rd_req && (csr_req_i.addr == AddrRxDescPort) && !rx_desc_empty_i;
  assign pop_rx_data_o = rd_req && (csr_req_i.addr == AddrRxDataPort) && !rx_data_empty_i;

  // Writes to a full queue are dropped here
  assign push_tx_desc_o = wr_req && (csr_req_i.addr == AddrTxDescPort) && !tx_desc_full_i;
  assign push_tx_data_o = wr_req && (csr_req_i.addr == AddrTxDataPort) && !tx_data_full_i;

  assign rd_valid_o = pop_rx_desc_o || pop_rx_data_o;
  assign rd_sel_o = (csr_req_i.addr == AddrRxDataPort) ? QSelRxData : QSelRxDesc;
  assign rd_thld_o = rd_req && (csr_req_i.addr == AddrThldCtrl);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      thld_q <= '0;
    end else if (wr_req && (csr_req_i.addr == AddrThldCtrl)) begin
      thld_q.raw <= csr_req_i.wdata;
    end
  end

  assign thld_ctrl_o = thld_q;

  strobe_onehot_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({pop_rx_desc_o, pop_rx_data_o, push_tx_desc_o, push_tx_data_o})
  ) else $error("more than one queue strobe in one cycle");

endmodule : tti_csr_decode

`default_nettype wire

//--- tti_queue.sv
// Single TTI queue, a circular buffer with push and pop ports
// Reports fill count, full, empty and a threshold flag in either direction
`timescale 1ns/1ps
`default_nettype none

module tti_queue (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             push_i,
  input  logic [tti_pkg::TtiDataWidth-1:0] push_data_i,
  input  logic                             pop_i,
  input  logic [tti_pkg::TtiCntWidth-1:0]  thld_i,
  input  logic                             thld_below_i,
  output logic [tti_pkg::TtiDataWidth-1:0] head_o,
  output tti_pkg::queue_status_t           status_o
);
  import tti_pkg::*;

  logic [TtiDataWidth-1:0] mem_q [TtiDepth];
  logic [TtiPtrWidth-1:0]  wr_ptr_q;
  logic [TtiPtrWidth-1:0]  rd_ptr_q;
  logic [TtiCntWidth-1:0]  count_q;
  logic                    full;
  logic                    empty;
  logic                    do_push;
  logic                    do_pop;

  assign full = (count_q == TtiCntWidth'(TtiDepth));
  assign empty = (count_q == '0);

  assign do_push = push_i && !full;
  assign do_pop = pop_i && !empty;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + TtiCntWidth'(do_push) - TtiCntWidth'(do_pop);
    end
  end

  assign head_o = mem_q[rd_ptr_q];

  assign status_o.full = full;
  assign status_o.empty = empty;
  // TX queues flag a shortfall, RX queues flag a fill level reached
  assign status_o.thld_flag = thld_below_i ? (count_q < thld_i) : (count_q >= thld_i);
  assign status_o.count = count_q;

  no_push_full_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full
  ) else $error("push into a full queue");

  no_pop_empty_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty
  ) else $error("pop from an empty queue");

  count_bound_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) count_q <= TtiCntWidth'(TtiDepth)
  ) else $error("queue count above depth");

endmodule : tti_queue

`default_nettype wire

//--- tti_csr_resp.sv
// CSR response stage for the TTI block
// Acknowledges every request one cycle later with the popped or register data
`timescale 1ns/1ps
`default_nettype none

module tti_csr_resp (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             req_i,
  input  logic                             rd_valid_i,
  input  tti_pkg::q_sel_e                  rd_sel_i,
  input  logic                             rd_thld_i,
  input  logic [tti_pkg::TtiDataWidth-1:0] rx_desc_head_i,
  input  logic [tti_pkg::TtiDataWidth-1:0] rx_data_head_i,
  input  tti_pkg::thld_ctrl_u              thld_ctrl_i,
  output tti_pkg::csr_rsp_t                csr_rsp_o
);
  import tti_pkg::*;

  logic                    ack_q;
  logic [TtiDataWidth-1:0] rdata_d;
  logic [TtiDataWidth-1:0] rdata_q;

  // Head is sampled at the same edge that pops it
  always_comb begin
    rdata_d = '0;
    if (rd_thld_i) begin
      rdata_d = thld_ctrl_i.raw;
    end else if (rd_valid_i) begin
      rdata_d = (rd_sel_i == QSelRxData) ? rx_data_head_i : rx_desc_head_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign csr_rsp_o.ack = ack_q;
  assign csr_rsp_o.rdata = ack_q ? rdata_q : '0;

  // Back-to-back acks need back-to-back requests
  ack_follows_req_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (csr_rsp_o.ack && $past(csr_rsp_o.ack)) |-> ($past(req_i) && $past(req_i, 2))
  ) else $error("ack held without matching requests");

endmodule : tti_csr_resp

`default_nettype wire

//--- tti.sv
// I3C target transaction interface with RX and TX descriptor and data queues
// Software uses the CSR strobe port, the bus engine uses valid/ready pairs
`timescale 1ns/1ps
`default_nettype none

module tti (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  tti_pkg::csr_req_t                csr_req_i,
  output tti_pkg::csr_rsp_t                csr_rsp_o,
  input  logic                             rx_desc_wvalid_i,
  output logic                             rx_desc_wready_o,
  input  logic [tti_pkg::TtiDataWidth-1:0] rx_desc_wdata_i,
  input  logic                             rx_data_wvalid_i,
  output logic                             rx_data_wready_o,
  input  logic [tti_pkg::TtiDataWidth-1:0] rx_data_wdata_i,
  output logic                             tx_desc_rvalid_o,
  input  logic                             tx_desc_rready_i,
  output logic [tti_pkg::TtiDataWidth-1:0] tx_desc_rdata_o,
  output logic                             tx_data_rvalid_o,
  input  logic                             tx_data_rready_i,
  output logic [tti_pkg::TtiDataWidth-1:0] tx_data_rdata_o,
  output tti_pkg::queue_status_t           rx_desc_status_o,
  output tti_pkg::queue_status_t           rx_data_status_o,
  output tti_pkg::queue_status_t           tx_desc_status_o,
  output tti_pkg::queue_status_t           tx_data_status_o,
  output tti_pkg::thld_ctrl_u              thld_ctrl_o
);
  import tti_pkg::*;

  logic                    pop_rx_desc;
  logic                    pop_rx_data;
  logic                    push_tx_desc;
  logic                    push_tx_data;
  q_sel_e                  rd_sel;
  logic                    rd_thld;
  logic                    rd_valid;
  logic [TtiDataWidth-1:0] rx_desc_head;
  logic [TtiDataWidth-1:0] rx_data_head;

  // Bus side handshakes
  assign rx_desc_wready_o = !rx_desc_status_o.full;
  assign rx_data_wready_o = !rx_data_status_o.full;
  assign tx_desc_rvalid_o = !tx_desc_status_o.empty;
  assign tx_data_rvalid_o = !tx_data_status_o.empty;

  tti_csr_decode csr_decode (
    .clk_i,
    .rst_n_i,
    .csr_req_i,
    .rx_desc_empty_i(rx_desc_status_o.empty),
    .rx_data_empty_i(rx_data_status_o.empty),
    .tx_desc_full_i (tx_desc_status_o.full),
    .tx_data_full_i (tx_data_status_o.full),
    .pop_rx_desc_o  (pop_rx_desc),
    .pop_rx_data_o  (pop_rx_data),
    .push_tx_desc_o (push_tx_desc),
    .push_tx_data_o (push_tx_data),
    .rd_sel_o       (rd_sel),
    .rd_thld_o      (rd_thld),
    .rd_valid_o     (rd_valid),
    .thld_ctrl_o
  );

  tti_queue rx_desc_queue (
    .clk_i,
    .rst_n_i,
    .push_i      (rx_desc_wvalid_i && rx_desc_wready_o),
    .push_data_i (rx_desc_wdata_i),
    .pop_i       (pop_rx_desc),
    .thld_i      (thld_ctrl_o.fld.rx_desc_thld[TtiCntWidth-1:0]),
    .thld_below_i(1'b0),
    .head_o      (rx_desc_head),
    .status_o    (rx_desc_status_o)
  );

  tti_queue rx_data_queue (
    .clk_i,
    .rst_n_i,
    .push_i      (rx_data_wvalid_i && rx_data_wready_o),
    .push_data_i (rx_data_wdata_i),
    .pop_i       (pop_rx_data),
    .thld_i      (thld_ctrl_o.fld.rx_data_thld[TtiCntWidth-1:0]),
    .thld_below_i(1'b0),
    .head_o      (rx_data_head),
    .status_o    (rx_data_status_o)
  );

  tti_queue tx_desc_queue (
    .clk_i,
    .rst_n_i,
    .push_i      (push_tx_desc),
    .push_data_i (csr_req_i.wdata),
    .pop_i       (tx_desc_rvalid_o && tx_desc_rready_i),
    .thld_i      (thld_ctrl_o.fld.tx_desc_thld[TtiCntWidth-1:0]),
    .thld_below_i(1'b1),
    .head_o      (tx_desc_rdata_o),
    .status_o    (tx_desc_status_o)
  );

  tti_queue tx_data_queue (
    .clk_i,
    .rst_n_i,
    .push_i      (push_tx_data),
    .push_data_i (csr_req_i.wdata),
    .pop_i       (tx_data_rvalid_o && tx_data_rready_i),
    .thld_i      (thld_ctrl_o.fld.tx_data_thld[TtiCntWidth-1:0]),
    .thld_below_i(1'b1),
    .head_o      (tx_data_rdata_o),
    .status_o    (tx_data_status_o)
  );

  tti_csr_resp csr_resp (
    .clk_i,
    .rst_n_i,
    .req_i         (csr_req_i.req),
    .rd_valid_i    (rd_valid),
    .rd_sel_i      (rd_sel),
    .rd_thld_i     (rd_thld),
    .rx_desc_head_i(rx_desc_head),
    .rx_data_head_i(rx_data_head),
    .thld_ctrl_i   (thld_ctrl_o),
    .csr_rsp_o
  );

endmodule : tti

`default_nettype wire

//--- tti_checker.sv
// Testbench monitor for the TTI block
// Keeps reference queues from the port activity and compares every DUT output
`timescale 1ns/1ps
`default_nettype none

module tti_checker (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  tti_pkg::csr_req_t                csr_req_i,
  input  tti_pkg::csr_rsp_t                csr_rsp_i,
  input  logic                             rx_desc_wvalid_i,
  input  logic                             rx_desc_wready_i,
  input  logic [tti_pkg::TtiDataWidth-1:0] rx_desc_wdata_i,
  input  logic                             rx_data_wvalid_i,
  input  logic                             rx_data_wready_i,
  input  logic [tti_pkg::TtiDataWidth-1:0] rx_data_wdata_i,
  input  logic                             tx_desc_rvalid_i,
  input  logic                             tx_desc_rready_i,
  input  logic [tti_pkg::TtiDataWidth-1:0] tx_desc_rdata_i,
  input  logic                             tx_data_rvalid_i,
  input  logic                             tx_data_rready_i,
  input  logic [tti_pkg::TtiDataWidth-1:0] tx_data_rdata_i,
  input  tti_pkg::queue_status_t           rx_desc_status_i,
  input  tti_pkg::queue_status_t           rx_data_status_i,
  input  tti_pkg::queue_status_t           tx_desc_status_i,
  input  tti_pkg::queue_status_t           tx_data_status_i,
  input  tti_pkg::thld_ctrl_u              thld_ctrl_i,
  input  logic                             tbl_chk_i,
  input  logic [tti_pkg::TtiDataWidth-1:0] tbl_exp_i,
  output int                               err_cnt_o
);
  import tti_pkg::*;

  logic [TtiDataWidth-1:0] rx_desc_q [$];
  logic [TtiDataWidth-1:0] rx_data_q [$];
  logic [TtiDataWidth-1:0] tx_desc_q [$];
  logic [TtiDataWidth-1:0] tx_data_q [$];
  thld_ctrl_u              thld;
  logic                    exp_ack;
  logic [TtiDataWidth-1:0] exp_rdata;
  logic                    tbl_pend;
  logic [TtiDataWidth-1:0] tbl_val;
  logic                    model_ok = 1'b0;
  int                      errors = 0;

  assign err_cnt_o = errors;

  task automatic check_word(input string name, input logic [TtiDataWidth-1:0] exp_w,
                            input logic [TtiDataWidth-1:0] act_w);
    if (exp_w !== act_w) begin
      errors++;
      $display("ERR %s expected %h actual %h at %0t", name, exp_w, act_w, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_b, input logic act_b);
    check_word(name, TtiDataWidth'(exp_b), TtiDataWidth'(act_b));
  endtask

  task automatic check_status(input string name, input int size,
                              input logic [TtiCntWidth-1:0] thld_val, input logic below,
                              input queue_status_t act_s);
    queue_status_t          exp_s;
    logic [TtiCntWidth-1:0] cnt;
    cnt = TtiCntWidth'(size);
    exp_s.full = (size == TtiDepth);
    exp_s.empty = (size == 0);
    // TX flags a shortfall, RX flags a level reached
    exp_s.thld_flag = below ? (cnt < thld_val) : (cnt >= thld_val);
    exp_s.count = cnt;
    check_word(name, TtiDataWidth'(exp_s), TtiDataWidth'(act_s));
  endtask

  task automatic reset_model();
    rx_desc_q.delete();
    rx_data_q.delete();
    tx_desc_q.delete();
    tx_data_q.delete();
    thld.raw = '0;
    exp_ack = 1'b0;
    exp_rdata = '0;
    tbl_pend = 1'b0;
    tbl_val = '0;
    model_ok = 1'b1;
  endtask

  // Advances the model across the coming edge with the inputs held for it
  task automatic step_model();
    logic                    rd;
    logic                    wr;
    logic [TtiAddrWidth-1:0] addr;
    logic                    rxd_push;
    logic                    rxa_push;
    logic                    txd_push;
    logic                    txa_push;
    logic                    txd_pop;
    logic                    txa_pop;
    rd = csr_req_i.req && !csr_req_i.we;
    wr = csr_req_i.req && csr_req_i.we;
    addr = csr_req_i.addr;
    // All enables see the queue state before the edge
    rxd_push = rx_desc_wvalid_i && (rx_desc_q.size() < TtiDepth);
    rxa_push = rx_data_wvalid_i && (rx_data_q.size() < TtiDepth);
    txd_push = wr && (addr == AddrTxDescPort) && (tx_desc_q.size() < TtiDepth);
    txa_push = wr && (addr == AddrTxDataPort) && (tx_data_q.size() < TtiDepth);
    txd_pop = tx_desc_rready_i && (tx_desc_q.size() != 0);
    txa_pop = tx_data_rready_i && (tx_data_q.size() != 0);
    exp_ack = csr_req_i.req;
    exp_rdata = '0;
    tbl_pend = tbl_chk_i;
    tbl_val = tbl_exp_i;
    if (rd && (addr == AddrThldCtrl)) begin
      exp_rdata = thld.raw;
    end
    if (rd && (addr == AddrRxDescPort) && (rx_desc_q.size() != 0)) begin
      exp_rdata = rx_desc_q.pop_front();
    end
    if (rd && (addr == AddrRxDataPort) && (rx_data_q.size() != 0)) begin
      exp_rdata = rx_data_q.pop_front();
    end
    if (txd_pop) begin
      check_word("tx_desc_rdata", tx_desc_q.pop_front(), tx_desc_rdata_i);
    end
    if (txa_pop) begin
      check_word("tx_data_rdata", tx_data_q.pop_front(), tx_data_rdata_i);
    end
    if (rxd_push) begin
      rx_desc_q.push_back(rx_desc_wdata_i);
    end
    if (rxa_push) begin
      rx_data_q.push_back(rx_data_wdata_i);
    end
    if (txd_push) begin
      tx_desc_q.push_back(csr_req_i.wdata);
    end
    if (txa_push) begin
      tx_data_q.push_back(csr_req_i.wdata);
    end
    if (wr && (addr == AddrThldCtrl)) begin
      thld.raw = csr_req_i.wdata;
    end
  endtask

  // Mid-cycle, both DUT outputs and driven inputs are settled
  always @(negedge clk_i) begin
    if (model_ok) begin
      check_bit("csr_rsp.ack", exp_ack, csr_rsp_i.ack);
      check_word("csr_rsp.rdata", exp_rdata, csr_rsp_i.rdata);
      if (tbl_pend) begin
        check_word("csr_rsp.rdata vs table", tbl_val, csr_rsp_i.rdata);
      end
      check_status("rx_desc_status", rx_desc_q.size(), thld.fld.rx_desc_thld[TtiCntWidth-1:0],
                   1'b0, rx_desc_status_i);
      check_status("rx_data_status", rx_data_q.size(), thld.fld.rx_data_thld[TtiCntWidth-1:0],
                   1'b0, rx_data_status_i);
      check_status("tx_desc_status", tx_desc_q.size(), thld.fld.tx_desc_thld[TtiCntWidth-1:0],
                   1'b1, tx_desc_status_i);
      check_status("tx_data_status", tx_data_q.size(), thld.fld.tx_data_thld[TtiCntWidth-1:0],
                   1'b1, tx_data_status_i);
      check_bit("rx_desc_wready", rx_desc_q.size() < TtiDepth, rx_desc_wready_i);
      check_bit("rx_data_wready", rx_data_q.size() < TtiDepth, rx_data_wready_i);
      check_bit("tx_desc_rvalid", tx_desc_q.size() != 0, tx_desc_rvalid_i);
      check_bit("tx_data_rvalid", tx_data_q.size() != 0, tx_data_rvalid_i);
      check_word("thld_ctrl", thld.raw, thld_ctrl_i.raw);
    end
    if (!rst_n_i) begin
      reset_model();
    end else if (model_ok) begin
      step_model();
    end
  end

endmodule : tti_checker

`default_nettype wire

//--- tb_tti.sv
// Testbench for the TTI block, applies a table of bus and CSR operations
// tti_checker does the comparing, this module drives stimulus and reports the result
`timescale 1ns/1ps
`default_nettype none

module tb_tti;
  import tti_pkg::*;

  typedef enum logic [2:0] {OpIdle, OpPush, OpPop, OpRead, OpWrite} op_e;
  typedef enum logic [2:0] {TgtRxDesc, TgtRxData, TgtTxDesc, TgtTxData, TgtThld, TgtNone} tgt_e;

  typedef struct packed {
    op_e                     op;
    tgt_e                    tgt;
    logic [TtiDataWidth-1:0] data;
    logic                    chk;
    logic [TtiDataWidth-1:0] exp_v;
  } row_t;

  logic                    clk = 1'b0;
  logic                    rst_n;
  csr_req_t                csr_req;
  csr_rsp_t                csr_rsp;
  logic                    rx_desc_wvalid;
  logic                    rx_desc_wready;
  logic [TtiDataWidth-1:0] rx_desc_wdata;
  logic                    rx_data_wvalid;
  logic                    rx_data_wready;
  logic [TtiDataWidth-1:0] rx_data_wdata;
  logic                    tx_desc_rvalid;
  logic                    tx_desc_rready;
  logic [TtiDataWidth-1:0] tx_desc_rdata;
  logic                    tx_data_rvalid;
  logic                    tx_data_rready;
  logic [TtiDataWidth-1:0] tx_data_rdata;
  queue_status_t           rx_desc_status;
  queue_status_t           rx_data_status;
  queue_status_t           tx_desc_status;
  queue_status_t           tx_data_status;
  thld_ctrl_u              thld_ctrl;
  logic                    tbl_chk;
  logic [TtiDataWidth-1:0] tbl_exp;
  int                      err_cnt;
  row_t                    rows [$];
  logic [31:0]             lfsr = 32'd51;
  int                      cycle_limit = 0;
  int                      cycles;

  always #10 clk = ~clk;

  tti tti_inst (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .csr_req_i       (csr_req),
    .csr_rsp_o       (csr_rsp),
    .rx_desc_wvalid_i(rx_desc_wvalid),
    .rx_desc_wready_o(rx_desc_wready),
    .rx_desc_wdata_i (rx_desc_wdata),
    .rx_data_wvalid_i(rx_data_wvalid),
    .rx_data_wready_o(rx_data_wready),
    .rx_data_wdata_i (rx_data_wdata),
    .tx_desc_rvalid_o(tx_desc_rvalid),
    .tx_desc_rready_i(tx_desc_rready),
    .tx_desc_rdata_o (tx_desc_rdata),
    .tx_data_rvalid_o(tx_data_rvalid),
    .tx_data_rready_i(tx_data_rready),
    .tx_data_rdata_o (tx_data_rdata),
    .rx_desc_status_o(rx_desc_status),
    .rx_data_status_o(rx_data_status),
    .tx_desc_status_o(tx_desc_status),
    .tx_data_status_o(tx_data_status),
    .thld_ctrl_o     (thld_ctrl)
  );

  tti_checker tti_checker_inst (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .csr_req_i       (csr_req),
    .csr_rsp_i       (csr_rsp),
    .rx_desc_wvalid_i(rx_desc_wvalid),
    .rx_desc_wready_i(rx_desc_wready),
    .rx_desc_wdata_i (rx_desc_wdata),
    .rx_data_wvalid_i(rx_data_wvalid),
    .rx_data_wready_i(rx_data_wready),
    .rx_data_wdata_i (rx_data_wdata),
    .tx_desc_rvalid_i(tx_desc_rvalid),
    .tx_desc_rready_i(tx_desc_rready),
    .tx_desc_rdata_i (tx_desc_rdata),
    .tx_data_rvalid_i(tx_data_rvalid),
    .tx_data_rready_i(tx_data_rready),
    .tx_data_rdata_i (tx_data_rdata),
    .rx_desc_status_i(rx_desc_status),
    .rx_data_status_i(rx_data_status),
    .tx_desc_status_i(tx_desc_status),
    .tx_data_status_i(tx_data_status),
    .thld_ctrl_i     (thld_ctrl),
    .tbl_chk_i       (tbl_chk),
    .tbl_exp_i       (tbl_exp),
    .err_cnt_o       (err_cnt)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_word(output logic [TtiDataWidth-1:0] w);
    for (int b = 0; b < TtiDataWidth; b++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[TtiDataWidth-2:0], lfsr[0]};
    end
  endtask

  function automatic logic [TtiAddrWidth-1:0] addr_of(input tgt_e tgt);
    case (tgt)
      TgtRxDesc: return AddrRxDescPort;
      TgtRxData: return AddrRxDataPort;
      TgtTxDesc: return AddrTxDescPort;
      TgtTxData: return AddrTxDataPort;
      TgtThld:   return AddrThldCtrl;
      default:   return 3'd6;
    endcase
  endfunction

  task automatic add_row(input op_e op, input tgt_e tgt, input logic [TtiDataWidth-1:0] data,
                         input logic chk, input logic [TtiDataWidth-1:0] exp_v);
    rows.push_back(row_t'{op, tgt, data, chk, exp_v});
  endtask

  task automatic build_table();
    logic [TtiDataWidth-1:0] w [6];
    logic [TtiDataWidth-1:0] v;
    logic [TtiDataWidth-1:0] first;
    logic [TtiDataWidth-1:0] thld_word;
    // Reset state, unmapped addresses and an empty queue read
    add_row(OpIdle, TgtNone, '0, 1'b0, '0);
    add_row(OpRead, TgtNone, '0, 1'b1, '0);
    next_word(v);
    add_row(OpWrite, TgtNone, v, 1'b0, '0);
    add_row(OpRead, TgtRxDesc, '0, 1'b1, '0);
    for (int i = 0; i < 6; i++) begin
      next_word(w[i]);
    end
    add_row(OpPush, TgtRxDesc, w[0], 1'b0, '0);
    add_row(OpPush, TgtRxDesc, w[1], 1'b0, '0);
    add_row(OpPush, TgtRxData, w[2], 1'b0, '0);
    add_row(OpRead, TgtRxDesc, '0, 1'b1, w[0]);
    add_row(OpRead, TgtRxData, '0, 1'b1, w[2]);
    add_row(OpRead, TgtRxDesc, '0, 1'b1, w[1]);
    add_row(OpRead, TgtRxDesc, '0, 1'b1, '0);
    // rx_desc 2, tx_desc 3, rx_data 1, tx_data 4
    thld_word = 32'h0203_0104;
    add_row(OpWrite, TgtThld, thld_word, 1'b0, '0);
    add_row(OpRead, TgtThld, '0, 1'b1, thld_word);
    add_row(OpWrite, TgtTxDesc, w[3], 1'b0, '0);
    add_row(OpWrite, TgtTxDesc, w[4], 1'b0, '0);
    add_row(OpWrite, TgtTxData, w[5], 1'b0, '0);
    add_row(OpIdle, TgtNone, '0, 1'b0, '0);
    add_row(OpPop, TgtTxDesc, '0, 1'b0, '0);
    add_row(OpPop, TgtTxDesc, '0, 1'b0, '0);
    add_row(OpPop, TgtTxData, '0, 1'b0, '0);
    // Ninth write finds the queue full
    for (int i = 0; i < 9; i++) begin
      next_word(v);
      add_row(OpWrite, TgtTxData, v, 1'b0, '0);
    end
    add_row(OpPop, TgtTxData, '0, 1'b0, '0);
    add_row(OpPop, TgtTxData, '0, 1'b0, '0);
    // Ninth push is held until a read makes room
    for (int i = 0; i < 9; i++) begin
      next_word(v);
      if (i == 0) begin
        first = v;
      end
      add_row(OpPush, TgtRxData, v, 1'b0, '0);
    end
    add_row(OpRead, TgtRxData, '0, 1'b1, first);
    add_row(OpIdle, TgtNone, '0, 1'b0, '0);
    add_row(OpIdle, TgtNone, '0, 1'b0, '0);
  endtask

  task automatic apply_row(input row_t r);
    case (r.op)
      OpPush: begin
        if (r.tgt == TgtRxDesc) begin
          rx_desc_wvalid = 1'b1;
          rx_desc_wdata = r.data;
        end else begin
          rx_data_wvalid = 1'b1;
          rx_data_wdata = r.data;
        end
      end
      OpPop: begin
        if (r.tgt == TgtTxDesc) begin
          tx_desc_rready = 1'b1;
        end else begin
          tx_data_rready = 1'b1;
        end
      end
      OpRead, OpWrite: begin
        csr_req.req = 1'b1;
        csr_req.we = (r.op == OpWrite);
        csr_req.addr = addr_of(r.tgt);
        csr_req.wdata = r.data;
        tbl_chk = r.chk;
        tbl_exp = r.exp_v;
      end
      default: begin
      end
    endcase
  endtask

  // A raised wvalid stays up until the queue takes the word
  task automatic step_cycle();
    logic desc_acc;
    logic data_acc;
    @(negedge clk);
    desc_acc = rx_desc_wvalid && rx_desc_wready;
    data_acc = rx_data_wvalid && rx_data_wready;
    @(posedge clk);
    #2;
    csr_req = '0;
    tbl_chk = 1'b0;
    tx_desc_rready = 1'b0;
    tx_data_rready = 1'b0;
    if (desc_acc) begin
      rx_desc_wvalid = 1'b0;
    end
    if (data_acc) begin
      rx_data_wvalid = 1'b0;
    end
  endtask

  initial begin
    rst_n = 1'b0;
    csr_req = '0;
    rx_desc_wvalid = 1'b0;
    rx_desc_wdata = '0;
    rx_data_wvalid = 1'b0;
    rx_data_wdata = '0;
    tx_desc_rready = 1'b0;
    tx_data_rready = 1'b0;
    tbl_chk = 1'b0;
    tbl_exp = '0;
    build_table();
    cycle_limit = rows.size() * 4 + 50;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    foreach (rows[i]) begin
      apply_row(rows[i]);
      step_cycle();
    end
    while (rx_desc_wvalid || rx_data_wvalid) begin
      step_cycle();
    end
    repeat (2) step_cycle();
    $display("checks done, %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule : tb_tti

`default_nettype wire

//--- project.f
tti_pkg.sv
tti_csr_decode.sv
tti_queue.sv
tti_csr_resp.sv
tti.sv
tti_checker.sv
tb_tti.sv

//--- Makefile
# Verilator build and run of the TTI testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_tti and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_tti -Mdir obj_dir -f project.f
	./obj_dir/Vtb_tti | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
